/* Bender.yml */
package:
  name: lvds_test

export_include_dirs:
  - hw

sources:
  - hw/lvds_test_pkg.sv
  - hw/mode_if.sv
  - hw/link_stat_if.sv
  - hw/mode_decode.sv
  - hw/prbs_link.sv
  - hw/link_result.sv
  - hw/lvds_test_top.sv
  - target: simulation
    files:
      - bench/lvds_test_monitor.sv
      - bench/lvds_test_checker.sv
      - bench/lvds_test_tb.sv

/* bench/lvds_test_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module lvds_test_checker
  import lvds_test_pkg::*;
(
  input wire            clk_ibufg,
  input wire            rst,
  input wire            clr,
  input var main_mode_e main_mode,
  input wire            phy_init,
  input wire [31:0]     err_cnt
);

  int fails = 0; // read by the testbench at the end.

  a_clr_pulse: assert property (@(posedge clk_ibufg) disable iff (rst) clr |=> !clr)
    else begin
      $error("clr stayed high for more than one cycle");
      fails++;
    end

  a_idle_unlocked: assert property (@(posedge clk_ibufg) disable iff (rst)
    (main_mode == mode_idle) |-> !phy_init)
    else begin
      $error("phy_init high while main_mode is idle");
      fails++;
    end

  // counter only drops on the edge right after clr.
  a_err_monotonic: assert property (@(posedge clk_ibufg) disable iff (rst)
    !$past(clr) |-> (err_cnt >= $past(err_cnt)))
    else begin
      $error("err_cnt decreased without clr");
      fails++;
    end

endmodule

bind link_result lvds_test_checker u_checker (
  .clk_ibufg (clk_ibufg),
  .rst       (rst),
  .clr       (m.clr),
  .main_mode (m.main_mode),
  .phy_init  (phy_init),
  .err_cnt   (err_cnt)
);

`default_nettype wire

/* bench/lvds_test_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module lvds_test_monitor
  import lvds_test_pkg::*;
(
  input var ctrl_word_t ctrl,
  input var main_mode_e main_mode,
  input var sub_mode_t  sub_mode,
  input wire [1:0]      dout,
  input wire [31:0]     recv_cnt,
  input wire [31:0]     err_cnt,
  input wire            phy_init
);

  int tests = 0;
  int tests_failed = 0;
  int checks = 0;
  int errors = 0;
  int test_errors = 0; // errors inside the running test.

  task automatic compare_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("FAIL t=%0t %s expected %h actual %h", $time, sig, exp, act);
    end
  endtask

  task automatic compare_at_least(input string sig, input logic [31:0] lo, input logic [31:0] act);
    checks++;
    if ($isunknown(act) || act < lo) begin
      errors++;
      test_errors++;
      $display("FAIL t=%0t %s expected >= %h actual %h", $time, sig, lo, act);
    end
  endtask

  task automatic report_fault(input string what);
    errors++;
    test_errors++;
    $display("error at t=%0t: %s", $time, what);
  endtask

  task automatic ctrl_is(input ctrl_word_t exp);
    compare_value("ctrl", {1'b0, exp}, {1'b0, ctrl});
  endtask

  task automatic mode_is(input main_mode_e exp_mode, input sub_mode_t exp_sub);
    compare_value("main_mode", 32'(exp_mode), 32'(main_mode));
    compare_value("sub_mode", 32'(exp_sub), 32'(sub_mode));
  endtask

  task automatic dout_is(input logic [1:0] exp);
    compare_value("dout", 32'(exp), 32'(dout));
  endtask

  task automatic recv_is(input logic [31:0] exp);
    compare_value("recv_cnt", exp, recv_cnt);
  endtask

  task automatic recv_at_least(input logic [31:0] lo);
    compare_at_least("recv_cnt", lo, recv_cnt);
  endtask

  task automatic err_is(input logic [31:0] exp);
    compare_value("err_cnt", exp, err_cnt);
  endtask

  task automatic lock_is(input logic exp);
    compare_value("phy_init", 32'(exp), 32'(phy_init));
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (test_errors != 0) begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests, name, test_errors);
    end else begin
      $display("test %0d %s: ok", tests, name);
    end
    test_errors = 0;
  endtask

  task automatic print_counts();
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests, tests_failed, checks, errors);
  endtask

endmodule

`default_nettype wire

/* bench/lvds_test_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lvds_test_cfg.svh"

module lvds_test_tb
  import lvds_test_pkg::*;
();

  localparam int clk_period = 40;
  localparam int deb        = `LVDS_DEBOUNCE_CYCLES;
  localparam int inj        = `LVDS_INJECT_PERIOD;
  localparam int press_len  = 2 * (deb + 6);
  localparam int lock_limit = 4 * `LVDS_LOCK_BITS;
  localparam int clean_len  = 200;
  localparam int flip_count = 5;
  // worst case of every test added up.
  localparam int test_cycles = 5 + (2 * deb + 2) + 8 * press_len + lock_limit + clean_len
                             + flip_count * 27 + 12 + press_len + 5 * inj + 2 * deb + 16
                             + lock_limit + press_len;

  logic        clk_ibufg;
  logic        rst;
  logic        btn_1;
  logic        btn_2;
  logic        btn_3;
  logic [1:0]  din;
  logic [1:0]  flip_mask; // loopback bit errors.
  logic [1:0]  dout;
  ctrl_word_t  ctrl;
  main_mode_e  main_mode;
  sub_mode_t   sub_mode;
  logic [31:0] recv_cnt;
  logic [31:0] err_cnt;
  logic        phy_init;
  logic [31:0] rng;

  lvds_test_top dut (
    .clk_ibufg (clk_ibufg),
    .rst       (rst),
    .btn_1     (btn_1),
    .btn_2     (btn_2),
    .btn_3     (btn_3),
    .din       (din),
    .dout      (dout),
    .ctrl      (ctrl),
    .main_mode (main_mode),
    .sub_mode  (sub_mode),
    .recv_cnt  (recv_cnt),
    .err_cnt   (err_cnt),
    .phy_init  (phy_init)
  );

  lvds_test_monitor mon (
    .ctrl      (ctrl),
    .main_mode (main_mode),
    .sub_mode  (sub_mode),
    .dout      (dout),
    .recv_cnt  (recv_cnt),
    .err_cnt   (err_cnt),
    .phy_init  (phy_init)
  );

  assign din = dout ^ flip_mask;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // sel, pd_bias, idset, hyst, drive, slew, pulls, test, por.
  function automatic ctrl_word_t ref_ctrl(input main_mode_e mode, input sub_mode_t sub);
    logic on;
    on = (mode != mode_idle);
    return {{4{on}}, {2{~on}}, 4'b0101, 2'b11, sub[1:0], sub[1:0], {2{sub[2]}},
            8'h00, 4'h0, ~on};
  endfunction

  // an isolated bit error is seen three times by a self synchronizing checker.
  function automatic logic [31:0] ref_err(input int flips, input int injections);
    return 32'(3 * (flips + injections));
  endfunction

  task automatic run_cycles(input int n);
    repeat (n) @(negedge clk_ibufg);
  endtask

  task automatic push_button(input int idx);
    btn_1 = (idx == 1);
    btn_2 = (idx == 2);
    btn_3 = (idx == 3);
    run_cycles(deb + 6);
    btn_1 = 1'b0;
    btn_2 = 1'b0;
    btn_3 = 1'b0;
    run_cycles(deb + 6);
  endtask

  task automatic hold_until_locked(input int limit);
    int n;
    n = 0;
    while (phy_init !== 1'b1 && n < limit) begin
      run_cycles(1);
      n++;
    end
    if (phy_init !== 1'b1) begin
      mon.report_fault("phy_init never rose within the lock limit");
    end
  endtask

  task automatic hold_until_cleared(input int limit);
    int n;
    n = 0;
    while (recv_cnt !== 32'd0 && n < limit) begin
      run_cycles(1);
      n++;
    end
    if (recv_cnt !== 32'd0) begin
      mon.report_fault("counters were not cleared after the btn_3 press");
    end
  endtask

  initial begin : clock_gen
    clk_ibufg = 1'b0;
    forever #(clk_period / 2) clk_ibufg = ~clk_ibufg;
  end

  initial begin : watchdog
    #((test_cycles + 200) * clk_period);
    $display("timeout: run did not finish within %0d cycles", test_cycles + 200);
    $display("Test failures found");
    $finish;
  end

  initial begin : stimulus
    int steps;
    int gap;
    int windows;
    logic [31:0] recv0;
    logic [31:0] err0;
    rst       = 1'b1;
    btn_1     = 1'b0;
    btn_2     = 1'b0;
    btn_3     = 1'b0;
    flip_mask = 2'b00;
    rng       = 32'h3f0c_ea0a;
    repeat (3) @(posedge clk_ibufg);
    @(negedge clk_ibufg);
    rst = 1'b0;
    run_cycles(1);

    mon.ctrl_is(ref_ctrl(mode_idle, 3'd0));
    mon.dout_is(2'b00);
    mon.recv_is(32'd0);
    mon.err_is(32'd0);
    mon.lock_is(1'b0);
    mon.finish_test("reset");

    btn_2 = 1'b1; // too short to pass the debounce.
    run_cycles(deb - 4);
    btn_2 = 1'b0;
    run_cycles(deb + 6);
    mon.mode_is(mode_idle, 3'd0);
    mon.ctrl_is(ref_ctrl(mode_idle, 3'd0));
    rng = xorshift32(rng);
    steps = 1 + int'(rng % 7);
    repeat (steps) push_button(2);
    push_button(1);
    mon.mode_is(mode_prbs, sub_mode_t'(steps));
    mon.ctrl_is(ref_ctrl(mode_prbs, sub_mode_t'(steps)));
    mon.finish_test("mode decode");

    hold_until_locked(lock_limit);
    recv0 = recv_cnt;
    run_cycles(clean_len);
    mon.recv_at_least(recv0 + 32'(2 * clean_len));
    mon.err_is(32'd0);
    mon.lock_is(1'b1);
    mon.finish_test("clean lock");

    for (int i = 0; i < flip_count; i++) begin
      rng = xorshift32(rng);
      gap = 10 + int'(rng % 16);
      run_cycles(gap);
      flip_mask = rng[31] ? 2'b10 : 2'b01;
      run_cycles(1);
      flip_mask = 2'b00;
    end
    run_cycles(12);
    mon.err_is(ref_err(flip_count, 0));
    mon.finish_test("loopback flips");

    push_button(1);
    mon.mode_is(mode_inject, sub_mode_t'(steps));
    mon.ctrl_is(ref_ctrl(mode_inject, sub_mode_t'(steps)));
    run_cycles(2 * inj); // past the first injection.
    rng = xorshift32(rng);
    windows = 1 + int'(rng % 3);
    err0 = err_cnt;
    run_cycles(inj * windows);
    mon.err_is(err0 + ref_err(0, windows));
    btn_3 = 1'b1;
    hold_until_cleared(deb + 10);
    mon.err_is(32'd0);
    mon.lock_is(1'b0);
    btn_3 = 1'b0;
    run_cycles(deb + 6);
    mon.finish_test("inject and clear");

    hold_until_locked(lock_limit); // clean gaps between injections are long enough.
    push_button(1);
    mon.mode_is(mode_idle, sub_mode_t'(steps));
    mon.ctrl_is(ref_ctrl(mode_idle, sub_mode_t'(steps)));
    mon.lock_is(1'b0);
    mon.finish_test("back to idle");

    if (dut.i_link_result.u_checker.fails != 0) begin
      mon.report_fault("bound assertions on the DUT failed");
    end
    mon.print_counts();
    if (mon.errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hw/link_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lvds_test_cfg.svh"

module link_result
  import lvds_test_pkg::*;
(
  input  wire         clk_ibufg,
  input  wire         rst,
  mode_if.dst         m,
  link_stat_if.dst    s,
  output logic [31:0] recv_cnt,
  output logic [31:0] err_cnt,
  output logic        phy_init
);

  localparam int lock_w = $clog2(`LVDS_LOCK_BITS + 1);
  localparam logic [lock_w-1:0] lock_last = lock_w'(`LVDS_LOCK_BITS - 1);

  lock_state_e       state;
  logic [lock_w-1:0] run;
  logic [1:0]        err_add;
  logic [32:0]       err_sum;
  logic [32:0]       recv_sum;

  assign err_add  = {1'b0, s.err_lane0} + {1'b0, s.err_lane1};
  assign err_sum  = {1'b0, err_cnt} + {31'd0, err_add};
  assign recv_sum = {1'b0, recv_cnt} + 33'd2;

  always_ff @(posedge clk_ibufg) begin
    if (rst || m.clr) begin
      recv_cnt <= '0;
      err_cnt  <= '0;
    end else begin
      if (s.chk_valid) begin
        recv_cnt <= recv_sum[32] ? '1 : recv_sum[31:0]; // saturate.
      end
      err_cnt <= err_sum[32] ? '1 : err_sum[31:0];
    end
  end

  always_ff @(posedge clk_ibufg) begin
    if (rst || m.clr || !m.active) begin
      state <= lock_hunt;
      run   <= '0;
    end else begin
      case (state)
        lock_hunt: begin
          if (s.chk_valid) begin
            if (!s.clean) begin
              run <= '0;
            end else if (run == lock_last) begin
              state <= lock_locked;
              run   <= '0;
            end else begin
              run <= run + 1'b1;
            end
          end
        end
        default: state <= lock_locked; // held until clr or idle.
      endcase
    end
  end

  // masked by active so it drops in the same cycle the mode goes idle.
  assign phy_init = (state == lock_locked) && m.active;

endmodule

`default_nettype wire

/* hw/link_stat_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface link_stat_if;

  logic chk_valid; // one per checked bit pair.
  logic err_lane0;
  logic err_lane1;
  logic clean;     // both lanes error free.

  modport src (
    output chk_valid,
    output err_lane0,
    output err_lane1,
    output clean
  );

  modport dst (
    input chk_valid,
    input err_lane0,
    input err_lane1,
    input clean
  );

endinterface

`default_nettype wire

/* hw/lvds_test_cfg.svh */
`ifndef LVDS_TEST_CFG_SVH
`define LVDS_TEST_CFG_SVH

// cycles a button level must hold before it is taken.
`define LVDS_DEBOUNCE_CYCLES 16

// consecutive clean check cycles before the link counts as locked.
`define LVDS_LOCK_BITS 32

// inject mode flips one lane 0 bit per this many cycles.
`define LVDS_INJECT_PERIOD 64

`endif

/* hw/lvds_test_pkg.sv */
`default_nettype none

package lvds_test_pkg;

  localparam int prbs_width = 7; // x^7+x^6+1.

  typedef enum logic [1:0] {
    mode_idle   = 2'd0,
    mode_prbs   = 2'd1,
    mode_inject = 2'd2
  } main_mode_e;

  typedef enum logic {
    lock_hunt   = 1'b0,
    lock_locked = 1'b1
  } lock_state_e;

  // bits 1..0 drive strength, bit 2 slew rate.
  typedef logic [2:0] sub_mode_t;

  // phy pin order, sel_rx_a at bit 30 down to por at bit 0.
  typedef struct packed {
    logic       sel_rx_a;
    logic       sel_rx_b;
    logic       sel_tx_a;
    logic       sel_tx_b;
    logic       pd_bias_a;
    logic       pd_bias_b;
    logic [1:0] idset_a;
    logic [1:0] idset_b;
    logic       hyst_a;
    logic       hyst_b;
    logic [1:0] drv_str_a;
    logic [1:0] drv_str_b;
    logic       sr_a;
    logic       sr_b;
    logic       puden_tx_a;
    logic       puden_tx_b;
    logic       puden_rx_a;
    logic       puden_rx_b;
    logic       pudpol_tx_a;
    logic       pudpol_tx_b;
    logic       pudpol_rx_a;
    logic       pudpol_rx_b;
    logic [1:0] test_a;
    logic [1:0] test_b;
    logic       por;
  } ctrl_word_t;

endpackage

`default_nettype wire

/* hw/lvds_test_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lvds_test_top
  import lvds_test_pkg::*;
(
  input  wire         clk_ibufg,
  input  wire         rst,
  input  wire         btn_1,
  input  wire         btn_2,
  input  wire         btn_3,
  input  wire  [1:0]  din,
  output logic [1:0]  dout,
  output ctrl_word_t  ctrl,
  output main_mode_e  main_mode,
  output sub_mode_t   sub_mode,
  output logic [31:0] recv_cnt,
  output logic [31:0] err_cnt,
  output logic        phy_init
);

  mode_if      i_mode ();
  link_stat_if i_stat ();

  mode_decode i_mode_decode (
    .clk_ibufg (clk_ibufg),
    .rst       (rst),
    .btn_1     (btn_1),
    .btn_2     (btn_2),
    .btn_3     (btn_3),
    .m         (i_mode.src),
    .ctrl      (ctrl)
  );

  prbs_link i_prbs_link (
    .clk_ibufg (clk_ibufg),
    .rst       (rst),
    .m         (i_mode.dst),
    .din       (din),
    .dout      (dout),
    .s         (i_stat.src)
  );

  link_result i_link_result (
    .clk_ibufg (clk_ibufg),
    .rst       (rst),
    .m         (i_mode.dst),
    .s         (i_stat.dst),
    .recv_cnt  (recv_cnt),
    .err_cnt   (err_cnt),
    .phy_init  (phy_init)
  );

  assign main_mode = i_mode.main_mode;
  assign sub_mode  = i_mode.sub_mode;

endmodule

`default_nettype wire

/* hw/mode_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lvds_test_cfg.svh"

module mode_decode
  import lvds_test_pkg::*;
(
  input  wire        clk_ibufg,
  input  wire        rst,
  input  wire        btn_1,
  input  wire        btn_2,
  input  wire        btn_3,
  mode_if.src        m,
  output ctrl_word_t ctrl
);

  localparam int deb_w = $clog2(`LVDS_DEBOUNCE_CYCLES + 1);
  localparam logic [deb_w-1:0] deb_last = deb_w'(`LVDS_DEBOUNCE_CYCLES - 1);

  logic [2:0]       btn_meta;
  logic [2:0]       btn_sync;
  logic [2:0]       stable;
  logic [2:0]       stable_d;
  logic [2:0]       rise;
  logic [deb_w-1:0] deb_cnt [3];
  main_mode_e       next_mode;

  function automatic ctrl_word_t make_ctrl(input logic act, input sub_mode_t sm);
    ctrl_word_t w;
    w = '0; // pulls and test fields stay zero.
    w.sel_rx_a  = act;
    w.sel_rx_b  = act;
    w.sel_tx_a  = act;
    w.sel_tx_b  = act;
    w.pd_bias_a = ~act;
    w.pd_bias_b = ~act;
    w.idset_a   = 2'b01;
    w.idset_b   = 2'b01;
    w.hyst_a    = 1'b1;
    w.hyst_b    = 1'b1;
    w.drv_str_a = sm[1:0];
    w.drv_str_b = sm[1:0];
    w.sr_a      = sm[2];
    w.sr_b      = sm[2];
    w.por       = ~act; // held in por while idle.
    return w;
  endfunction

  // two flop sync, then a per button stability counter.
  always_ff @(posedge clk_ibufg) begin
    if (rst) begin
      btn_meta <= '0;
      btn_sync <= '0;
      stable   <= '0;
      stable_d <= '0;
      for (int i = 0; i < 3; i++) begin
        deb_cnt[i] <= '0;
      end
    end else begin
      btn_meta <= {btn_3, btn_2, btn_1};
      btn_sync <= btn_meta;
      stable_d <= stable;
      for (int i = 0; i < 3; i++) begin
        if (btn_sync[i] == stable[i]) begin
          deb_cnt[i] <= '0;
        end else if (deb_cnt[i] == deb_last) begin
          stable[i]  <= btn_sync[i];
          deb_cnt[i] <= '0;
        end else begin
          deb_cnt[i] <= deb_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign rise = stable & ~stable_d;

  always_comb begin
    case (m.main_mode)
      mode_idle: next_mode = mode_prbs;
      mode_prbs: next_mode = mode_inject;
      default:   next_mode = mode_idle;
    endcase
  end

  always_ff @(posedge clk_ibufg) begin
    if (rst) begin
      m.main_mode <= mode_idle;
      m.active    <= 1'b0;
      m.sub_mode  <= '0;
      m.clr       <= 1'b0;
    end else begin
      m.clr <= rise[2];
      if (rise[0]) begin
        m.main_mode <= next_mode;
        m.active    <= (next_mode != mode_idle);
      end
      if (rise[1]) begin
        m.sub_mode <= m.sub_mode + 3'd1; // wraps at 8.
      end
    end
  end

  always_ff @(posedge clk_ibufg) begin
    if (rst) begin
      ctrl <= make_ctrl(1'b0, '0);
    end else begin
      ctrl <= make_ctrl(m.active, m.sub_mode);
    end
  end

endmodule

`default_nettype wire

/* hw/mode_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mode_if
  import lvds_test_pkg::*;
();

  main_mode_e main_mode;
  sub_mode_t  sub_mode;
  logic       clr;    // one cycle pulse.
  logic       active; // main_mode is not idle.

  modport src (
    output main_mode,
    output sub_mode,
    output clr,
    output active
  );

  modport dst (
    input main_mode,
    input sub_mode,
    input clr,
    input active
  );

endinterface

`default_nettype wire

/* hw/prbs_link.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lvds_test_cfg.svh"

module prbs_link
  import lvds_test_pkg::*;
(
  input  wire        clk_ibufg,
  input  wire        rst,
  mode_if.dst        m,
  input  wire  [1:0] din,
  output logic [1:0] dout,
  link_stat_if.src   s
);

  localparam int inj_w = $clog2(`LVDS_INJECT_PERIOD + 1);
  localparam logic [inj_w-1:0] inj_last = inj_w'(`LVDS_INJECT_PERIOD - 1);
  localparam logic [prbs_width-1:0] seed_lane0 = 7'h7f;
  localparam logic [prbs_width-1:0] seed_lane1 = 7'h55;
  // one stale sample plus a full register before errors count.
  localparam int sync_len = prbs_width + 1;
  localparam int fill_w   = $clog2(sync_len + 1);

  logic [prbs_width-1:0] gen [2];
  logic [prbs_width-1:0] chk [2];
  logic [1:0]            gen_fb;
  logic [1:0]            chk_fb;
  logic [1:0]            err_now;
  logic [inj_w-1:0]      inj_cnt;
  logic                  inj_hit;
  logic [fill_w-1:0]     fill;
  logic                  synced;

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      gen_fb[i] = gen[i][prbs_width-1] ^ gen[i][prbs_width-2];
      chk_fb[i] = chk[i][prbs_width-1] ^ chk[i][prbs_width-2];
    end
  end

  assign inj_hit = (m.main_mode == mode_inject) && (inj_cnt == inj_last);

  always_ff @(posedge clk_ibufg) begin
    if (rst) begin
      gen[0]  <= seed_lane0;
      gen[1]  <= seed_lane1;
      dout    <= '0;
      inj_cnt <= '0;
    end else begin
      if (m.main_mode == mode_inject) begin
        inj_cnt <= inj_hit ? '0 : inj_cnt + 1'b1;
      end else begin
        inj_cnt <= '0;
      end
      if (m.active) begin
        for (int i = 0; i < 2; i++) begin
          gen[i] <= {gen[i][prbs_width-2:0], gen_fb[i]};
        end
        dout <= gen_fb ^ {1'b0, inj_hit}; // lfsr itself is never disturbed.
      end
    end
  end

  // receive side, each lane predicts its next bit from the last seven.
  always_ff @(posedge clk_ibufg) begin
    if (m.active) begin
      for (int i = 0; i < 2; i++) begin
        chk[i] <= {chk[i][prbs_width-2:0], din[i]};
      end
    end
  end

  always_ff @(posedge clk_ibufg) begin
    if (rst || !m.active) begin
      fill <= '0;
    end else if (!synced) begin
      fill <= fill + 1'b1;
    end
  end

  assign synced  = (fill == fill_w'(sync_len));
  assign err_now = (din ^ chk_fb) & {2{synced}};

  always_ff @(posedge clk_ibufg) begin
    if (rst) begin
      s.chk_valid <= 1'b0;
      s.err_lane0 <= 1'b0;
      s.err_lane1 <= 1'b0;
      s.clean     <= 1'b0;
    end else begin
      s.chk_valid <= m.active;
      s.err_lane0 <= m.active & err_now[0];
      s.err_lane1 <= m.active & err_now[1];
      s.clean     <= m.active & ~|err_now;
    end
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/lvds_test_pkg.sv
hw/mode_if.sv
hw/link_stat_if.sv
hw/mode_decode.sv
hw/prbs_link.sv
hw/link_result.sv
hw/lvds_test_top.sv
bench/lvds_test_monitor.sv
bench/lvds_test_checker.sv
bench/lvds_test_tb.sv
